//--- tests/pixel_gen_stim.txt
# test cmd udlr shot video_on repeat x y x_hi y_hi rgb_hex
# udlr is up down left right, x_hi y_hi bound scans only
1 reset 0000 0 1 1 0 0 0 0 00000000
1 probe 0000 0 1 1 40 420 0 0 000ffc00
1 probe 0000 0 1 1 100 100 0 0 000003ff
2 scan 0000 0 1 16 32 31 608 68 00000000
2 scan 0000 0 1 16 32 68 608 228 000003ff
2 scan 0000 0 1 16 32 228 608 260 3ffffc00
2 scan 0000 0 1 16 64 260 608 420 3ffffc00
2 scan 0000 0 1 16 64 420 608 452 00000000
2 scan 0000 0 0 24 0 0 640 480 00000000
3 reset 0000 0 1 1 0 0 0 0 00000000
3 frame 0001 0 1 10 0 0 0 0 00000000
3 probe 0000 0 1 1 41 420 0 0 00000000
3 probe 0000 0 1 1 73 420 0 0 000ffc00
3 frame 0010 0 1 20 0 0 0 0 00000000
3 probe 0000 0 1 1 32 420 0 0 000ffc00
3 probe 0000 0 1 1 31 420 0 0 00000000
3 probe 0000 0 1 1 64 420 0 0 00000000
4 reset 0000 0 1 1 0 0 0 0 00000000
4 frame 0001 0 1 10 0 0 0 0 00000000
4 frame 0000 1 1 1 0 0 0 0 00000000
4 frame 0000 0 1 3 0 0 0 0 00000000
4 probe 0000 0 1 1 80 430 0 0 3ff00000
4 probe 0000 0 1 1 72 430 0 0 000ffc00
5 reset 0000 0 1 1 0 0 0 0 00000000
5 frame 0000 1 1 1 0 0 0 0 00000000
5 frame 0000 0 1 3 0 0 0 0 00000000
5 probe 0000 0 1 1 46 406 0 0 3ff00000
5 frame 0000 0 1 60 0 0 0 0 00000000
5 probe 0000 0 1 1 46 406 0 0 3ffffc00
5 probe 0000 0 1 1 46 100 0 0 000003ff
5 probe 0000 0 1 1 46 30 0 0 00000000

//--- all.f
src/video_pkg.sv
src/game_pkg.sv
src/tank_motion.sv
src/shell_motion.sv
src/pixel_mixer.sv
src/pixel_gen.sv
tests/pixel_gen_tb.sv

//--- tests/pixel_gen_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_gen_tb;

    // clock half period and drive/sample offsets in ns
    localparam int HALF_PERIOD  = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 10;

    // bounds on file reading and random draws
    localparam int MAX_LINES = 1000;
    localparam int MAX_DRAWS = 20000;

    // retrace coordinate, one frame tick per cycle spent here
    localparam logic [9:0] RETRACE_X = 10'd0;
    localparam logic [9:0] RETRACE_Y = 10'd491;

    // DUT inputs
    logic        clk_50MHz;
    logic        reset;
    logic        up;
    logic        down;
    logic        left;
    logic        right;
    logic        shot;
    logic        video_on;
    logic [9:0]  x;
    logic [9:0]  y;

    // DUT output
    logic [29:0] rgb;

    // xorshift state
    logic [31:0] rand_state;

    // per-test and overall counts
    int cur_test;
    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int tests_run;
    int tests_failed;

    // one parsed stim line
    logic [8*200-1:0] line;
    logic [8*8-1:0]   cmd;
    logic [3:0]       udlr;
    logic             fire;
    logic             von;
    logic [29:0]      exp_rgb;
    int               test_num;
    int               reps;
    int               sx;
    int               sy;
    int               sx_hi;
    int               sy_hi;

    pixel_gen pixel_gen_i (
        .clk_50MHz (clk_50MHz),
        .reset     (reset),
        .up        (up),
        .down      (down),
        .left      (left),
        .right     (right),
        .shot      (shot),
        .video_on  (video_on),
        .x         (x),
        .y         (y),
        .rgb       (rgb)
    );

    // 50 MHz clock
    initial begin
        clk_50MHz = 1'b0;
        forever #HALF_PERIOD clk_50MHz = ~clk_50MHz;
    end

    // 32-bit xorshift step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // compare the current pixel colour
    task automatic check_rgb(input logic [29:0] expected);
        test_checks++;
        total_checks++;
        if (rgb !== expected) begin
            $display("ERR %0t rgb expected %h got %h at pixel %0d,%0d",
                     $time, expected, rgb, x, y);
            test_errors++;
            total_errors++;
        end
    endtask

    // hold reset low for 8 cycles, release just after an edge
    task automatic apply_reset;
        reset = 1'b0;
        {up, down, left, right} = 4'b0000;
        shot = 1'b0;
        video_on = 1'b0;
        x = 10'd0;
        y = 10'd0;
        repeat (8) @(posedge clk_50MHz);
        #DRIVE_DELAY;
        reset = 1'b1;
    endtask

    // park on the retrace pixel, one tick per cycle
    task automatic run_frames(input int count);
        x = RETRACE_X;
        y = RETRACE_Y;
        repeat (count) begin
            @(posedge clk_50MHz);
            #DRIVE_DELAY;
        end
        // off the retrace pixel so no stray tick follows
        y = 10'd0;
    endtask

    // drive one pixel, sample mid-cycle
    task automatic probe_pixel(input logic [9:0] px, input logic [9:0] py,
                               input logic [29:0] expected);
        x = px;
        y = py;
        #SAMPLE_DELAY;
        check_rgb(expected);
        @(posedge clk_50MHz);
        #DRIVE_DELAY;
    endtask

    // random visible pixels, only those inside the rectangle are checked
    task automatic scan_zone(input int count, input int xlo, input int ylo,
                             input int xhi, input int yhi, input logic [29:0] expected);
        int         found;
        int         draws;
        logic [9:0] px;
        logic [9:0] py;
        found = 0;
        draws = 0;
        while (found < count && draws < MAX_DRAWS) begin
            rand_state = next_random(rand_state);
            px = rand_state % 640;
            rand_state = next_random(rand_state);
            py = rand_state % 480;
            draws++;
            if (px >= xlo && px < xhi && py >= ylo && py < yhi) begin
                probe_pixel(px, py, expected);
                found++;
            end
        end
        if (found < count) begin
            $display("scan timed out in test %0d, only %0d of %0d points after %0d draws",
                     cur_test, found, count, draws);
            test_errors++;
            total_errors++;
        end
    endtask

    // one summary line per finished test
    task automatic report_test;
        if (cur_test != 0) begin
            tests_run++;
            if (test_errors != 0) begin
                tests_failed++;
                $display("test %0d failed, %0d checks, %0d errors",
                         cur_test, test_checks, test_errors);
            end else begin
                $display("test %0d ok, %0d checks", cur_test, test_checks);
            end
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int fd;
        int lines;
        int fields;
        int rc;
        reset = 1'b0;
        {up, down, left, right} = 4'b0000;
        shot = 1'b0;
        video_on = 1'b0;
        x = 10'd0;
        y = 10'd0;
        rand_state = 32'd38538;
        cur_test = 0;
        test_checks = 0;
        test_errors = 0;
        total_checks = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        apply_reset;
        fd = $fopen("tests/pixel_gen_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stim file tests/pixel_gen_stim.txt");
            total_errors++;
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < MAX_LINES) begin
                line = '0;
                cmd = '0;
                rc = $fgets(line, fd);
                lines++;
                // comment and blank lines give fewer fields and are skipped
                fields = 0;
                if (rc != 0) begin
                    fields = $sscanf(line, "%d %s %b %b %b %d %d %d %d %d %h",
                                     test_num, cmd, udlr, fire, von, reps,
                                     sx, sy, sx_hi, sy_hi, exp_rgb);
                end
                if (fields == 11) begin
                    if (test_num != cur_test) begin
                        report_test;
                        cur_test = test_num;
                    end
                    {up, down, left, right} = udlr;
                    shot = fire;
                    video_on = von;
                    if (cmd == "reset") begin
                        apply_reset;
                    end else if (cmd == "frame") begin
                        run_frames(reps);
                    end else if (cmd == "probe") begin
                        probe_pixel(sx, sy, exp_rgb);
                    end else if (cmd == "scan") begin
                        scan_zone(reps, sx, sy, sx_hi, sy_hi, exp_rgb);
                    end else begin
                        $display("unknown command on stim line %0d", lines);
                        test_errors++;
                        total_errors++;
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("stim file longer than %0d lines, reading stopped", MAX_LINES);
                total_errors++;
            end
            $fclose(fd);
            report_test;
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0 && tests_failed == 0 && tests_run > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/pixel_gen.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_gen (
    input  wire                       clk_50MHz,
    input  wire                       reset,
    input  wire                       up,
    input  wire                       down,
    input  wire                       left,
    input  wire                       right,
    input  wire                       shot,
    input  wire                       video_on,
    input  wire video_pkg::coord_t    x,
    input  wire video_pkg::coord_t    y,
    output video_pkg::rgb_t           rgb
);

    // high for one clock per frame, start of vertical retrace
    logic              frame_tick;

    // tank state
    video_pkg::coord_t tank_x;
    video_pkg::coord_t tank_y;
    game_pkg::facing_t facing;

    // shell state
    video_pkg::coord_t shell_x;
    video_pkg::coord_t shell_y;
    logic              shell_flying;

    assign frame_tick = (x == video_pkg::REFRESH_X) && (y == video_pkg::REFRESH_Y);

    // buttons move the tank once per frame
    tank_motion tank_motion_i (
        .clk_50MHz  (clk_50MHz),
        .reset      (reset),
        .frame_tick (frame_tick),
        .up         (up),
        .down       (down),
        .left       (left),
        .right      (right),
        .tank_x     (tank_x),
        .tank_y     (tank_y),
        .facing     (facing)
    );

    // shell follows the tank until fired
    shell_motion shell_motion_i (
        .clk_50MHz    (clk_50MHz),
        .reset        (reset),
        .frame_tick   (frame_tick),
        .shot         (shot),
        .tank_x       (tank_x),
        .tank_y       (tank_y),
        .facing       (facing),
        .shell_x      (shell_x),
        .shell_y      (shell_y),
        .shell_flying (shell_flying)
    );

    // combinational colour for the current pixel
    pixel_mixer pixel_mixer_i (
        .video_on     (video_on),
        .x            (x),
        .y            (y),
        .tank_x       (tank_x),
        .tank_y       (tank_y),
        .shell_x      (shell_x),
        .shell_y      (shell_y),
        .shell_flying (shell_flying),
        .rgb          (rgb)
    );

endmodule

`default_nettype wire

//--- src/pixel_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_mixer (
    input  wire                       video_on,
    input  wire video_pkg::coord_t    x,
    input  wire video_pkg::coord_t    y,
    input  wire video_pkg::coord_t    tank_x,
    input  wire video_pkg::coord_t    tank_y,
    input  wire video_pkg::coord_t    shell_x,
    input  wire video_pkg::coord_t    shell_y,
    input  wire                       shell_flying,
    output video_pkg::rgb_t           rgb
);

    // pixel inside the visible area
    logic            visible;

    // shared column span of the background
    logic            in_zone_cols;

    // one flag per coloured band
    logic            water_on;
    logic            upper_sand_on;
    logic            street_on;

    // sprite hits
    logic            tank_on;
    logic            shell_on;

    video_pkg::rgb_t zone_rgb;

    assign visible = video_on && (x <= video_pkg::X_MAX) && (y <= video_pkg::Y_MAX);

    assign in_zone_cols = (x >= video_pkg::ZONE_X_LO) && (x < video_pkg::ZONE_X_HI);

    assign water_on      = in_zone_cols && (y >= video_pkg::WATER_Y_LO) &&
                           (y < video_pkg::WATER_Y_HI);
    assign upper_sand_on = in_zone_cols && (y >= video_pkg::UPPER_SAND_Y_LO) &&
                           (y < video_pkg::UPPER_SAND_Y_HI);
    assign street_on     = in_zone_cols && (y >= video_pkg::STREET_Y_LO) &&
                           (y < video_pkg::STREET_Y_HI);

    // square hit tests, corner included, far side excluded
    assign tank_on  = (x >= tank_x) && (x < tank_x + game_pkg::TANK_SIZE) &&
                      (y >= tank_y) && (y < tank_y + game_pkg::TANK_SIZE);
    assign shell_on = (x >= shell_x) && (x < shell_x + game_pkg::SHELL_SIZE) &&
                      (y >= shell_y) && (y < shell_y + game_pkg::SHELL_SIZE);

    // background colour by band
    always_comb begin
        if (water_on) begin
            zone_rgb = video_pkg::BLUE;
        end else if (upper_sand_on || street_on) begin
            zone_rgb = video_pkg::YELLOW;
        end else begin
            // top road, lower sand, border and off-field area
            zone_rgb = video_pkg::BLACK;
        end
    end

    // blanking first, then tank over shell over background
    always_comb begin
        if (!visible) begin
            rgb = video_pkg::BLACK;
        end else if (tank_on) begin
            rgb = game_pkg::TANK_COLOR;
        end else if (shell_flying && shell_on) begin
            rgb = game_pkg::SHELL_COLOR;
        end else begin
            rgb = zone_rgb;
        end
    end

endmodule

`default_nettype wire

//--- src/shell_motion.sv
`timescale 1ns/100ps
`default_nettype none

module shell_motion (
    input  wire                       clk_50MHz,
    input  wire                       reset,
    input  wire                       frame_tick,
    input  wire                       shot,
    input  wire video_pkg::coord_t    tank_x,
    input  wire video_pkg::coord_t    tank_y,
    input  wire game_pkg::facing_t    facing,
    output video_pkg::coord_t         shell_x,
    output video_pkg::coord_t         shell_y,
    output logic                      shell_flying
);

    // idle rides along in the tank, flying moves on its own
    typedef enum logic {
        IDLE   = 1'b0,
        FLYING = 1'b1
    } state_t;

    state_t            state;
    state_t            state_next;

    // heading latched at the shot
    game_pkg::facing_t dir;
    game_pkg::facing_t dir_next;

    // corner after one step along dir
    video_pkg::coord_t step_x;
    video_pkg::coord_t step_y;
    logic              step_out;

    video_pkg::coord_t x_next;
    video_pkg::coord_t y_next;

    // one step in the stored direction
    always_comb begin
        step_x = shell_x;
        step_y = shell_y;
        case (dir)
            game_pkg::UP:    step_y = shell_y - game_pkg::SHELL_STEP;
            game_pkg::DOWN:  step_y = shell_y + game_pkg::SHELL_STEP;
            game_pkg::LEFT:  step_x = shell_x - game_pkg::SHELL_STEP;
            default:         step_x = shell_x + game_pkg::SHELL_STEP;
        endcase
    end

    // stepped corner past any exit limit ends the flight
    assign step_out = (step_x < game_pkg::SHELL_X_MIN) || (step_x > game_pkg::SHELL_X_MAX) ||
                      (step_y < game_pkg::SHELL_Y_MIN) || (step_y > game_pkg::SHELL_Y_MAX);

    always_comb begin
        state_next = state;
        dir_next   = dir;
        x_next     = shell_x;
        y_next     = shell_y;
        case (state)
            IDLE: begin
                // parked at the tank centre
                x_next = tank_x + game_pkg::SHELL_OFFSET;
                y_next = tank_y + game_pkg::SHELL_OFFSET;
                if (shot) begin
                    state_next = FLYING;
                    dir_next   = facing;
                end
            end
            default: begin
                // left at the exit point, next idle tick re-centres it
                x_next = step_x;
                y_next = step_y;
                if (step_out) begin
                    state_next = IDLE;
                end
            end
        endcase
    end

    // one update per frame tick
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            state   <= IDLE;
            dir     <= game_pkg::UP;
            shell_x <= game_pkg::TANK_X_START + game_pkg::SHELL_OFFSET;
            shell_y <= game_pkg::TANK_Y_START + game_pkg::SHELL_OFFSET;
        end else if (frame_tick) begin
            state   <= state_next;
            dir     <= dir_next;
            shell_x <= x_next;
            shell_y <= y_next;
        end
    end

    assign shell_flying = (state == FLYING);

endmodule

`default_nettype wire

//--- src/tank_motion.sv
`timescale 1ns/100ps
`default_nettype none

module tank_motion (
    input  wire                       clk_50MHz,
    input  wire                       reset,
    input  wire                       frame_tick,
    input  wire                       up,
    input  wire                       down,
    input  wire                       left,
    input  wire                       right,
    output video_pkg::coord_t         tank_x,
    output video_pkg::coord_t         tank_y,
    output game_pkg::facing_t         facing
);

    // far edges of the tank square
    video_pkg::coord_t tank_right;
    video_pkg::coord_t tank_bottom;

    // one step in that direction keeps the tank in the field
    logic can_up;
    logic can_down;
    logic can_left;
    logic can_right;

    // values loaded at the next frame tick
    video_pkg::coord_t x_next;
    video_pkg::coord_t y_next;
    game_pkg::facing_t facing_next;

    assign tank_right  = tank_x + game_pkg::TANK_SIZE - 10'd1;
    assign tank_bottom = tank_y + game_pkg::TANK_SIZE - 10'd1;

    // field limit checks, one per direction
    assign can_up    = tank_y > (game_pkg::FIELD_TOP + game_pkg::TANK_STEP);
    assign can_down  = tank_bottom < (game_pkg::FIELD_BOTTOM - game_pkg::TANK_STEP);
    assign can_left  = tank_x >= (game_pkg::FIELD_LEFT + game_pkg::TANK_STEP);
    assign can_right = tank_right < (game_pkg::FIELD_RIGHT - game_pkg::TANK_STEP);

    // first pressed button wins, up > down > left > right
    // facing follows the button even when blocked
    always_comb begin
        x_next      = tank_x;
        y_next      = tank_y;
        facing_next = facing;
        if (up) begin
            facing_next = game_pkg::UP;
            if (can_up) begin
                y_next = tank_y - game_pkg::TANK_STEP;
            end
        end else if (down) begin
            facing_next = game_pkg::DOWN;
            if (can_down) begin
                y_next = tank_y + game_pkg::TANK_STEP;
            end
        end else if (left) begin
            facing_next = game_pkg::LEFT;
            if (can_left) begin
                x_next = tank_x - game_pkg::TANK_STEP;
            end
        end else if (right) begin
            facing_next = game_pkg::RIGHT;
            if (can_right) begin
                x_next = tank_x + game_pkg::TANK_STEP;
            end
        end
    end

    // position and facing move once per frame
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            tank_x <= game_pkg::TANK_X_START;
            tank_y <= game_pkg::TANK_Y_START;
            facing <= game_pkg::UP;
        end else if (frame_tick) begin
            tank_x <= x_next;
            tank_y <= y_next;
            facing <= facing_next;
        end
    end

endmodule

`default_nettype wire

//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

    // direction the tank points, also the shell heading
    typedef enum logic [1:0] {
        UP    = 2'd0,
        DOWN  = 2'd1,
        LEFT  = 2'd2,
        RIGHT = 2'd3
    } facing_t;

    // tank square side and speed in pixels per frame
    localparam video_pkg::coord_t TANK_SIZE = 10'd32;
    localparam video_pkg::coord_t TANK_STEP = 10'd1;

    // start corner, left edge of the lower sand band
    localparam video_pkg::coord_t TANK_X_START = 10'd32;
    localparam video_pkg::coord_t TANK_Y_START = 10'd416;

    // play field the tank must stay inside
    localparam video_pkg::coord_t FIELD_LEFT   = 10'd32;
    localparam video_pkg::coord_t FIELD_RIGHT  = 10'd608;
    localparam video_pkg::coord_t FIELD_TOP    = 10'd32;
    localparam video_pkg::coord_t FIELD_BOTTOM = 10'd448;

    // shell square side and speed in pixels per frame
    localparam video_pkg::coord_t SHELL_SIZE = 10'd4;
    localparam video_pkg::coord_t SHELL_STEP = 10'd8;

    // tank corner to shell corner, puts the shell in the tank centre
    localparam video_pkg::coord_t SHELL_OFFSET = TANK_SIZE / 2 - SHELL_SIZE / 2;

    // shell leaves flight once its corner passes these
    localparam video_pkg::coord_t SHELL_X_MIN = 10'd28;
    localparam video_pkg::coord_t SHELL_X_MAX = 10'd607;
    localparam video_pkg::coord_t SHELL_Y_MIN = 10'd28;
    localparam video_pkg::coord_t SHELL_Y_MAX = 10'd447;

    // sprite colours, drawn solid
    localparam video_pkg::rgb_t TANK_COLOR  = video_pkg::GREEN;
    localparam video_pkg::rgb_t SHELL_COLOR = video_pkg::RED;

endpackage

`default_nettype wire

//--- src/video_pkg.sv
`default_nettype none

package video_pkg;

    // pixel coordinate, wide enough for the whole 800x525 raster
    typedef logic [9:0] coord_t;

    // bits per colour channel
    localparam int CHANNEL_W = 10;

    // packed colour, red in the top bits
    typedef struct packed {
        logic [CHANNEL_W-1:0] red;
        logic [CHANNEL_W-1:0] green;
        logic [CHANNEL_W-1:0] blue;
    } rgb_t;

    // last visible column and row
    localparam coord_t X_MAX = 10'd639;
    localparam coord_t Y_MAX = 10'd479;

    // start of vertical retrace, once per frame
    localparam coord_t REFRESH_X = 10'd0;
    localparam coord_t REFRESH_Y = 10'd491;

    // solid colours, each channel fully on or off
    localparam rgb_t RED    = '{red: {CHANNEL_W{1'b1}}, green: '0, blue: '0};
    localparam rgb_t GREEN  = '{red: '0, green: {CHANNEL_W{1'b1}}, blue: '0};
    localparam rgb_t BLUE   = '{red: '0, green: '0, blue: {CHANNEL_W{1'b1}}};
    localparam rgb_t YELLOW = '{red: {CHANNEL_W{1'b1}}, green: {CHANNEL_W{1'b1}}, blue: '0};
    localparam rgb_t BLACK  = '{red: '0, green: '0, blue: '0};

    // column span shared by every background zone, hi excluded
    localparam coord_t ZONE_X_LO = 10'd32;
    localparam coord_t ZONE_X_HI = 10'd608;

    // row spans of the five zones, lo included, hi excluded
    localparam coord_t TOP_ROAD_Y_LO   = 10'd31;
    localparam coord_t TOP_ROAD_Y_HI   = 10'd68;
    localparam coord_t WATER_Y_LO      = 10'd68;
    localparam coord_t WATER_Y_HI      = 10'd228;
    localparam coord_t UPPER_SAND_Y_LO = 10'd228;
    localparam coord_t UPPER_SAND_Y_HI = 10'd260;
    localparam coord_t STREET_Y_LO     = 10'd260;
    localparam coord_t STREET_Y_HI     = 10'd420;
    localparam coord_t LOWER_SAND_Y_LO = 10'd420;
    localparam coord_t LOWER_SAND_Y_HI = 10'd452;

endpackage

`default_nettype wire
